// File: verilog/coupe_audio_pkg.sv
package coupe_audio_pkg;

	// ====================
	// Sample format
	// ====================
	localparam int SAMPLE_W = 18;         // Mix word and SID sample width

	// ====================
	// I/O port map
	// ====================
	localparam logic [7:0] PORT_BORDER     = 8'hFE;
	localparam logic [7:0] PORT_LPT_DATA   = 8'hE8;  // Printer data latch
	localparam logic [7:0] PORT_LPT_STROBE = 8'hE9;  // Printer strobe picks the channel

	// Bit positions inside the written bytes
	localparam int BORDER_EAR_BIT = 4;
	localparam int STROBE_BIT     = 0;

	// ====================
	// Timing
	// ====================
	localparam int MEG_DIV   = 96;        // clk_sys cycles per 1 MHz tick
	localparam int MEG_CNT_W = $clog2(MEG_DIV);
	localparam logic [MEG_CNT_W-1:0] MEG_LAST = MEG_CNT_W'(MEG_DIV - 1);

	// ====================
	// Mix weights
	// ====================
	localparam int PSG_GAIN_SHIFT = 2;    // Doubled byte sits two bits up
	localparam int EAR_WEIGHT_BIT = 17;   // Beeper adds half of full scale

endpackage

// File: verilog/port_audio_regs.sv
`timescale 1ns/1ps

module port_audio_regs (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       port_we,
	input  logic [7:0] port_addr,
	input  logic [7:0] port_data,
	output logic       ear,
	output logic [7:0] vox_l,
	output logic [7:0] vox_r
);

	// ====================
	// Write edge detect
	// ====================
	logic       we_q;       // port_we one cycle back
	logic       wr_pulse;   // One cycle per CPU write
	logic [7:0] wr_addr;
	logic [7:0] wr_data;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			we_q     <= 1'b0;
			wr_pulse <= 1'b0;
		end else begin
			we_q     <= port_we;
			wr_pulse <= port_we & ~we_q;
		end
	end

	// Address and data taken on the same edge as the pulse
	always_ff @(posedge clk_sys) begin
		if (port_we & ~we_q) begin
			wr_addr <= port_addr;
			wr_data <= port_data;
		end
	end

	// Port decode
	logic sel_border;
	logic sel_lpt_data;
	logic sel_lpt_strobe;

	assign sel_border     = wr_pulse && (wr_addr == coupe_audio_pkg::PORT_BORDER);
	assign sel_lpt_data   = wr_pulse && (wr_addr == coupe_audio_pkg::PORT_LPT_DATA);
	assign sel_lpt_strobe = wr_pulse && (wr_addr == coupe_audio_pkg::PORT_LPT_STROBE);

	// ====================
	// Border beeper
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ear <= 1'b0;
		end else if (sel_border) begin
			ear <= wr_data[coupe_audio_pkg::BORDER_EAR_BIT];
		end
	end

	// ====================
	// Printer port DAC
	// ====================
	logic [7:0] lpt_data;     // Byte waiting for a strobe
	logic       strobe_q;     // Last strobe level written
	logic       strobe_new;

	assign strobe_new = wr_data[coupe_audio_pkg::STROBE_BIT];

	always_ff @(posedge clk_sys) begin
		if (sel_lpt_data) begin
			lpt_data <= wr_data;
		end
	end

	// Rising strobe loads left, falling strobe loads right
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vox_l    <= 8'd0;
			vox_r    <= 8'd0;
			strobe_q <= 1'b0;
		end else if (sel_lpt_strobe) begin
			if (~strobe_q & strobe_new) begin
				vox_l <= lpt_data;
			end
			if (strobe_q & ~strobe_new) begin
				vox_r <= lpt_data;
			end
			strobe_q <= strobe_new;   // Same level loads nothing
		end
	end

endmodule

// File: verilog/sid_fader.sv
`timescale 1ns/1ps

module sid_fader (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 sid_active,
	input  logic [coupe_audio_pkg::SAMPLE_W-1:0] sid_raw,
	output logic [coupe_audio_pkg::SAMPLE_W-1:0] sid_out
);

	// ====================
	// 1 MHz enable
	// ====================
	logic [coupe_audio_pkg::MEG_CNT_W-1:0] meg_cnt;
	logic                                  ce_1m;

	assign ce_1m = (meg_cnt == coupe_audio_pkg::MEG_LAST);   // Last count of the period

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			meg_cnt <= '0;
		end else if (ce_1m) begin
			meg_cnt <= '0;
		end else begin
			meg_cnt <= meg_cnt + 1'b1;
		end
	end

	// ====================
	// Attenuation
	// ====================
	logic [coupe_audio_pkg::SAMPLE_W-1:0] att;

	// Starts fully muted and slides one step per tick
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			att <= '1;
		end else if (ce_1m) begin
			if (sid_active && (att != '0)) begin
				att <= att - 1'b1;   // Fade in
			end else if (!sid_active && !(&att)) begin
				att <= att + 1'b1;   // Fade out
			end
		end
	end

	// ====================
	// Output
	// ====================
	logic [coupe_audio_pkg::SAMPLE_W-1:0] sid_offset;

	// Signed to offset binary
	assign sid_offset = {~sid_raw[coupe_audio_pkg::SAMPLE_W-1],
		sid_raw[coupe_audio_pkg::SAMPLE_W-2:0]};

	// Clamp at zero once the attenuation passes the sample
	assign sid_out = (sid_offset > att) ? (sid_offset - att) : '0;

endmodule

// File: verilog/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic [7:0]                           psg_l,
	input  logic [7:0]                           psg_r,
	input  logic                                 ear,
	input  logic [7:0]                           vox_l,
	input  logic [7:0]                           vox_r,
	input  logic [coupe_audio_pkg::SAMPLE_W-1:0] sid_out,
	output logic [coupe_audio_pkg::SAMPLE_W-1:0] mix_l,
	output logic [coupe_audio_pkg::SAMPLE_W-1:0] mix_r
);

	// Byte doubled to 16 bits then shifted up, so 1028 per step
	function automatic logic [coupe_audio_pkg::SAMPLE_W-1:0] scale_byte(input logic [7:0] b);
		logic [coupe_audio_pkg::SAMPLE_W-1:0] w;
		w = {b, b};
		w = w << coupe_audio_pkg::PSG_GAIN_SHIFT;
		return w;
	endfunction

	// ====================
	// Source terms
	// ====================
	logic [coupe_audio_pkg::SAMPLE_W-1:0] ear_term;
	logic [coupe_audio_pkg::SAMPLE_W-1:0] sum_l;
	logic [coupe_audio_pkg::SAMPLE_W-1:0] sum_r;

	assign ear_term = {{(coupe_audio_pkg::SAMPLE_W-1){1'b0}}, ear}
		<< coupe_audio_pkg::EAR_WEIGHT_BIT;

	// Beeper and SID are shared, PSG and DAC are per channel
	assign sum_l = scale_byte(psg_l) + scale_byte(vox_l) + ear_term + sid_out;   // Wraps
	assign sum_r = scale_byte(psg_r) + scale_byte(vox_r) + ear_term + sid_out;

	// ====================
	// Output register
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mix_l <= '0;
			mix_r <= '0;
		end else begin
			mix_l <= sum_l;
			mix_r <= sum_r;
		end
	end

endmodule

// File: verilog/coupe_audio.sv
`timescale 1ns/1ps

module coupe_audio (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 port_we,
	input  logic [7:0]                           port_addr,
	input  logic [7:0]                           port_data,
	input  logic [7:0]                           psg_l,
	input  logic [7:0]                           psg_r,
	input  logic                                 sid_active,
	input  logic [coupe_audio_pkg::SAMPLE_W-1:0] sid_raw,
	output logic [coupe_audio_pkg::SAMPLE_W-1:0] mix_l,
	output logic [coupe_audio_pkg::SAMPLE_W-1:0] mix_r
);

	logic                                 ear;       // Border beeper bit
	logic [7:0]                           vox_l;     // Printer DAC left
	logic [7:0]                           vox_r;     // Printer DAC right
	logic [coupe_audio_pkg::SAMPLE_W-1:0] sid_out;   // Faded SID sample

	// ====================
	// Sources
	// ====================
	port_audio_regs u_port_audio_regs (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.port_we   (port_we),
		.port_addr (port_addr),
		.port_data (port_data),
		.ear       (ear),
		.vox_l     (vox_l),
		.vox_r     (vox_r)
	);

	sid_fader u_sid_fader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sid_active (sid_active),
		.sid_raw    (sid_raw),
		.sid_out    (sid_out)
	);

	// ====================
	// Mix
	// ====================
	audio_mixer u_audio_mixer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.psg_l   (psg_l),
		.psg_r   (psg_r),
		.ear     (ear),
		.vox_l   (vox_l),
		.vox_r   (vox_r),
		.sid_out (sid_out),
		.mix_l   (mix_l),
		.mix_r   (mix_r)
	);

endmodule

// File: test/tb_coupe_audio.sv
`timescale 1ns/1ps

module tb_coupe_audio;

	localparam int    RESET_CYCLES = 10;
	localparam int    LINE_MARGIN  = 4;     // Cycles per command on top of the waits
	localparam string TEST_FILE    = "test/coupe_audio_tests.txt";

	logic                                 clk_sys;
	logic                                 reset;
	logic                                 port_we;
	logic [7:0]                           port_addr;
	logic [7:0]                           port_data;
	logic [7:0]                           psg_l;
	logic [7:0]                           psg_r;
	logic                                 sid_active;
	logic [coupe_audio_pkg::SAMPLE_W-1:0] sid_raw;
	logic [coupe_audio_pkg::SAMPLE_W-1:0] mix_l;
	logic [coupe_audio_pkg::SAMPLE_W-1:0] mix_r;

	string lines[$];            // Command lines without comments
	int    limit_cycles = 0;    // Watchdog budget in cycles
	int    check_count;

	// ====================
	// DUT
	// ====================
	coupe_audio dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.port_we    (port_we),
		.port_addr  (port_addr),
		.port_data  (port_data),
		.psg_l      (psg_l),
		.psg_r      (psg_r),
		.sid_active (sid_active),
		.sid_raw    (sid_raw),
		.mix_l      (mix_l),
		.mix_r      (mix_r)
	);

	always #20 clk_sys = ~clk_sys;   // 40 ns period

	// ====================
	// Ending the run
	// ====================
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(input string name,
		input logic [coupe_audio_pkg::SAMPLE_W-1:0] actual,
		input logic [coupe_audio_pkg::SAMPLE_W-1:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, actual, expected));
		end
	endtask

	// Watchdog
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk_sys);
		abort_run($sformatf("Timeout: the test file was not finished after %0d clock cycles",
			limit_cycles));
	end

	// ====================
	// Test file
	// ====================
	// Fields per command including its name or zero when unknown
	function automatic int field_count(input string cmd);
		case (cmd)
			"write", "psg", "sid", "expect": return 3;
			"wait": return 2;
			default: return 0;
		endcase
	endfunction

	task automatic load_tests();
		int    fd;
		int    wait_total;
		int    value;
		string line;
		string cmd;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			abort_run({"Cannot open ", TEST_FILE, " for reading"});
		end
		wait_total = 0;
		while ($fgets(line, fd) != 0) begin
			cmd   = "";
			value = 0;
			void'($sscanf(line, "%s %d", cmd, value));
			if (cmd != "" && cmd.getc(0) != "#") begin
				if (cmd == "wait") begin
					wait_total += value;
				end
				// Drop the line end so messages stay on one line
				while (line.len() > 0 && line.getc(line.len() - 1) inside {8'h0a, 8'h0d}) begin
					line = line.substr(0, line.len() - 2);
				end
				lines.push_back(line);
			end
		end
		$fclose(fd);
		limit_cycles = RESET_CYCLES + wait_total + LINE_MARGIN * lines.size();
	endtask

	// port_we stays up for two edges
	task automatic port_write(input logic [7:0] addr, input logic [7:0] data);
		port_addr <= addr;
		port_data <= data;
		port_we   <= 1'b1;
		repeat (2) @(posedge clk_sys);
		port_we   <= 1'b0;   // A write that follows at once keeps it high
	endtask

	// Starts and ends on a rising edge
	task automatic run_command(input string line);
		string cmd;
		int    a;
		int    b;
		int    n;
		int    want;
		cmd = "";
		void'($sscanf(line, "%s", cmd));
		want = field_count(cmd);
		if (cmd == "wait") begin
			n = $sscanf(line, "%s %d", cmd, a);
		end else begin
			n = $sscanf(line, "%s %h %h", cmd, a, b);
		end
		if (want == 0) begin
			abort_run({"Unknown command in the test file: ", line});
		end
		if (n != want) begin
			abort_run({"Wrong number of fields in the test file line: ", line});
		end
		case (cmd)
			"write": port_write(a[7:0], b[7:0]);
			"psg": begin
				psg_l <= a[7:0];
				psg_r <= b[7:0];
			end
			"sid": begin
				sid_active <= a[0];
				sid_raw    <= b[coupe_audio_pkg::SAMPLE_W-1:0];
			end
			"wait": repeat (a) @(posedge clk_sys);
			"expect": begin
				@(negedge clk_sys);   // Mix words settled since the last rising edge
				check_value("mix_l", mix_l, a[coupe_audio_pkg::SAMPLE_W-1:0]);
				check_value("mix_r", mix_r, b[coupe_audio_pkg::SAMPLE_W-1:0]);
				check_count++;
				@(posedge clk_sys);
			end
			default: ;
		endcase
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		clk_sys     = 1'b0;
		reset       = 1'b1;
		port_we     = 1'b0;
		port_addr   = 8'h00;
		port_data   = 8'h00;
		psg_l       = 8'h00;
		psg_r       = 8'h00;
		sid_active  = 1'b0;
		sid_raw     = '0;
		check_count = 0;
		load_tests();
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;   // Fader steps count from this edge
		foreach (lines[i]) begin
			run_command(lines[i]);
		end
		if (check_count == 0) begin
			abort_run("The test file holds no expect commands");
		end else begin
			$display("Checked %0d expect lines", check_count);
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

// File: coupe_audio.f
verilog/coupe_audio_pkg.sv
verilog/port_audio_regs.sv
verilog/sid_fader.sv
verilog/audio_mixer.sv
verilog/coupe_audio.sv
test/tb_coupe_audio.sv

// File: Makefile
# Verilator build and run of the coupe_audio testbench
TOP := tb_coupe_audio

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f coupe_audio.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: test/coupe_audio_tests.txt
# Columns: command, then its fields in hex (wait counts are decimal)
# write addr data | psg left right | sid active sample | wait cycles | expect mix_l mix_r
#
# Reset state, then PSG bytes alone at 1028 per step
expect 00000 00000
psg 01 00
wait 1
expect 00404 00000
psg 00 80
wait 1
expect 00000 20200
psg 12 34
wait 1
expect 04848 0D0D0
psg 00 00
wait 1
expect 00000 00000
# Border beeper on bit 4
write FE 10
wait 1
expect 20000 20000
# Back-to-back writes keep port_we high, so the second one is not counted
write FE 10
write FE 00
wait 1
expect 20000 20000
# Other port, then border with bit 4 clear
write FD 00
wait 1
expect 20000 20000
write FE EF
wait 1
expect 00000 00000
# Printer DAC, data byte alone changes nothing
write E8 40
wait 1
expect 00000 00000
# Rising strobe loads left
write E9 01
wait 1
expect 10100 00000
# Falling strobe loads right
write E8 22
wait 1
write E9 00
wait 1
expect 10100 08888
# Same strobe level loads neither
write E8 77
wait 1
write E9 00
wait 1
expect 10100 08888
write E9 01
wait 1
expect 1DDDC 08888
# Wrap of PSG, DAC and beeper modulo 2^18
write FE 10
wait 1
psg FF FF
wait 1
expect 3DDD8 28884
psg 80 80
wait 1
expect 1DFDC 08A88
psg 00 00
write FE 00
wait 1
expect 1DDDC 08888
# SID held inactive since reset, full-scale sample adds nothing
sid 0 1FFFF
wait 1
expect 1DDDC 08888
# Raised at cycle 66, ticks at multiples of 96
sid 1 1FFFF
wait 78
expect 1DDDD 08889
wait 96
expect 1DDDE 0888A
wait 288
expect 1DDE1 0888D
# Mid-scale sample sits below the attenuation
sid 1 00000
wait 1
expect 1DDDC 08888
sid 1 1FFFF
wait 1
expect 1DDE1 0888D
# Lowered, fades back one step per tick
sid 0 1FFFF
wait 89
expect 1DDE0 0888C
wait 96
expect 1DDDF 0888B
wait 288
expect 1DDDC 08888
# Stays muted
wait 192
expect 1DDDC 08888
